/* source/retx_defs.svh */
// retransmit engine widths, table and fifo depths, packet geometry
`ifndef RETX_DEFS_SVH
`define RETX_DEFS_SVH

// descriptor table
`define RETX_IDX_W          5
`define RETX_TABLE_DEPTH    32

// one fixed packet per retransmit request
`define RETX_PKT_LEN        1024
`define RETX_PKT_SHIFT      10

// on-board buffer and host address widths
`define RETX_RAM_ADDR_W     16
`define RETX_DMA_ADDR_W     64

// sequence numbers and queue pairs
`define RETX_PSN_W          24
`define RETX_QPN_W          24
`define RETX_MSN_QPS        16

// request order fifo
`define RETX_FIFO_DEPTH     32
`define RETX_FIFO_AFULL     28

`endif

/* source/wqe_pkg.sv */
// descriptor word, seen either as one raw word or as its fields
`include "retx_defs.svh"

package wqe_pkg;

    // msb first, total length sits at bit 0
    typedef struct packed {
        logic [19:0]                  task_id;
        logic                         fence;
        logic [2:0]                   prio;
        logic [15:0]                  src_port;
        logic [`RETX_QPN_W-1:0]       dst_qpn;
        logic [`RETX_DMA_ADDR_W-1:0]  raddr;
        logic [`RETX_DMA_ADDR_W-1:0]  laddr;
        logic [31:0]                  rip;
        logic [31:0]                  total_len;
    } wqe_fields_t;

    typedef union packed {
        logic [255:0] raw;
        wqe_fields_t  f;
    } wqe_word_u;

endpackage

/* source/tx_hdr_pkg.sv */
// transmit header word, seen either as one raw word or as its fields
`include "retx_defs.svh"

package tx_hdr_pkg;

    // msb first, remote info pointer sits at bit 0
    typedef struct packed {
        logic [`RETX_DMA_ADDR_W-1:0]  raddr;
        logic [19:0]                  task_id;
        logic [2:0]                   prio;
        logic                         fence;
        logic [`RETX_PSN_W-1:0]       psn;
        // msn shares the psn width
        logic [`RETX_PSN_W-1:0]       msn;
        logic [`RETX_QPN_W-1:0]       dst_qpn;
        logic [`RETX_QPN_W-1:0]       src_qpn;
        logic [15:0]                  src_port;
        logic [31:0]                  rip;
    } tx_hdr_fields_t;

    typedef union packed {
        logic [231:0]   raw;
        tx_hdr_fields_t f;
    } tx_hdr_u;

endpackage

/* source/retx_if.sv */
// dma read request bundle and descriptor table read port
`timescale 1ns/100ps
`include "retx_defs.svh"

interface dma_req_if;
    logic [`RETX_DMA_ADDR_W-1:0] dma_addr;
    logic [`RETX_RAM_ADDR_W-1:0] ram_addr;
    logic [`RETX_IDX_W-1:0]      tag;
    logic                        valid;
    logic                        ready;

    modport master (output dma_addr, ram_addr, tag, valid, input ready);
    modport slave (input dma_addr, ram_addr, tag, valid, output ready);
endinterface

// lookup by index, answered combinationally
interface tbl_rd_if;
    logic [`RETX_IDX_W-1:0]  rd_idx;
    wqe_pkg::wqe_word_u      entry;
    logic [`RETX_QPN_W-1:0]  src_qpn;
    logic [`RETX_PSN_W-1:0]  msn;
    logic                    active;

    modport master (
        output rd_idx,
        input  entry, src_qpn, msn, active
    );
    modport slave (
        input  rd_idx,
        output entry, src_qpn, msn, active
    );
endinterface

/* source/psn_fifo.sv */
// request order fifo of psns, first word fall through, almost-full flag
`timescale 1ns/100ps
`include "retx_defs.svh"

module psn_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_push,
    input  logic [`RETX_PSN_W-1:0]  i_push_psn,
    input  logic                    i_pop,
    output logic [`RETX_PSN_W-1:0]  o_head_psn,
    output logic                    o_empty,
    output logic                    o_afull
);

    localparam int PTR_W = $clog2(`RETX_FIFO_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `RETX_FIFO_DEPTH;
    localparam logic [PTR_W:0] AFULL = `RETX_FIFO_AFULL;

    logic [`RETX_PSN_W-1:0] mem [`RETX_FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic                   full;

    assign full       = (count == DEPTH);
    assign o_empty    = (count == '0);
    assign o_afull    = (count >= AFULL);
    assign o_head_psn = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_psn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (i_push && !i_pop) begin
                count <= count + 1'b1;
            end else if (i_pop && !i_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) i_push |-> !full || i_pop)
        else $error("psn_fifo: push while full");
    assert property (@(posedge clk) disable iff (rst) i_pop |-> !o_empty)
        else $error("psn_fifo: pop while empty");

endmodule

/* source/dma_req_skid.sv */
// dma read request output stage, registered ready with one skid slot
`timescale 1ns/100ps
`include "retx_defs.svh"

module dma_req_skid (
    input  logic                        clk,
    input  logic                        rst,
    dma_req_if.slave                    req_in,
    output logic [`RETX_DMA_ADDR_W-1:0] o_dma_addr,
    output logic [`RETX_RAM_ADDR_W-1:0] o_dma_ram_addr,
    output logic [`RETX_IDX_W-1:0]      o_dma_tag,
    output logic                        o_dma_valid,
    input  logic                        i_dma_ready
);

    logic [`RETX_DMA_ADDR_W-1:0] tmp_addr;
    logic [`RETX_RAM_ADDR_W-1:0] tmp_ram_addr;
    logic [`RETX_IDX_W-1:0]      tmp_tag;
    logic                        tmp_valid;
    logic                        ready_reg;
    logic                        ready_early;
    logic                        load_out;
    logic                        load_tmp;
    logic                        tmp_to_out;

    assign req_in.ready = ready_reg;

    // stay ready unless the skid slot could fill next cycle
    assign ready_early = i_dma_ready || (!tmp_valid && (!o_dma_valid || !req_in.valid));

    always_comb begin
        load_out   = 1'b0;
        load_tmp   = 1'b0;
        tmp_to_out = 1'b0;
        if (ready_reg) begin
            if (i_dma_ready || !o_dma_valid) begin
                load_out = 1'b1;
            end else begin
                load_tmp = 1'b1;
            end
        end else if (i_dma_ready) begin
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_dma_valid <= 1'b0;
            tmp_valid   <= 1'b0;
            ready_reg   <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (load_out) begin
                o_dma_valid <= req_in.valid;
            end else if (tmp_to_out) begin
                o_dma_valid <= tmp_valid;
            end
            if (load_tmp) begin
                tmp_valid <= req_in.valid;
            end else if (tmp_to_out) begin
                tmp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            o_dma_addr     <= req_in.dma_addr;
            o_dma_ram_addr <= req_in.ram_addr;
            o_dma_tag      <= req_in.tag;
        end else if (tmp_to_out) begin
            o_dma_addr     <= tmp_addr;
            o_dma_ram_addr <= tmp_ram_addr;
            o_dma_tag      <= tmp_tag;
        end
        if (load_tmp) begin
            tmp_addr     <= req_in.dma_addr;
            tmp_ram_addr <= req_in.ram_addr;
            tmp_tag      <= req_in.tag;
        end
    end

    // a stalled request holds until taken
    assert property (@(posedge clk) disable iff (rst)
        o_dma_valid && !i_dma_ready
        |=> o_dma_valid && $stable({o_dma_addr, o_dma_ram_addr, o_dma_tag}))
        else $error("dma_req_skid: request changed while stalled");

endmodule

/* source/wqe_table.sv */
// descriptor table with active bits and per-qp message sequence counters
`timescale 1ns/100ps
`include "retx_defs.svh"

module wqe_table (
    input  logic                    clk,
    input  logic                    rst,
    input  wqe_pkg::wqe_word_u      i_wqe_data,
    input  logic [`RETX_QPN_W-1:0]  i_wqe_qpn,
    input  logic [`RETX_IDX_W-1:0]  i_wqe_id,
    input  logic                    i_wqe_valid,
    input  logic [`RETX_IDX_W-1:0]  i_cpl_id,
    input  logic                    i_cpl_valid,
    tbl_rd_if.slave                 tx_rd,
    tbl_rd_if.slave                 retx_rd
);

    localparam int SEL_W = $clog2(`RETX_MSN_QPS);

    wqe_pkg::wqe_word_u            entry_mem [`RETX_TABLE_DEPTH];
    logic [`RETX_QPN_W-1:0]        qpn_mem   [`RETX_TABLE_DEPTH];
    logic [`RETX_PSN_W-1:0]        msn_mem   [`RETX_TABLE_DEPTH];
    logic [`RETX_PSN_W-1:0]        msn_cnt   [`RETX_MSN_QPS];
    logic [`RETX_TABLE_DEPTH-1:0]  active;
    logic [SEL_W-1:0]              msn_sel;

    // low qpn bits pick the message counter
    assign msn_sel = i_wqe_qpn[SEL_W-1:0];

    always_ff @(posedge clk) begin
        if (i_wqe_valid) begin
            entry_mem[i_wqe_id] <= i_wqe_data;
            qpn_mem[i_wqe_id]   <= i_wqe_qpn;
            msn_mem[i_wqe_id]   <= msn_cnt[msn_sel];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= '0;
            for (int q = 0; q < `RETX_MSN_QPS; q++) begin
                msn_cnt[q] <= '0;
            end
        end else begin
            if (i_cpl_valid) begin
                active[i_cpl_id] <= 1'b0;
            end
            // a descriptor landing with its own completion stays active
            if (i_wqe_valid) begin
                active[i_wqe_id] <= 1'b1;
                msn_cnt[msn_sel] <= msn_cnt[msn_sel] + 1'b1;
            end
        end
    end

    assign tx_rd.entry     = entry_mem[tx_rd.rd_idx];
    assign tx_rd.src_qpn   = qpn_mem[tx_rd.rd_idx];
    assign tx_rd.msn       = msn_mem[tx_rd.rd_idx];
    assign tx_rd.active    = active[tx_rd.rd_idx];

    assign retx_rd.entry   = entry_mem[retx_rd.rd_idx];
    assign retx_rd.src_qpn = qpn_mem[retx_rd.rd_idx];
    assign retx_rd.msn     = msn_mem[retx_rd.rd_idx];
    assign retx_rd.active  = active[retx_rd.rd_idx];

    // an index is reused only after its completion
    assert property (@(posedge clk) disable iff (rst)
        i_wqe_valid |-> !active[i_wqe_id] || (i_cpl_valid && i_cpl_id == i_wqe_id))
        else $error("wqe_table: descriptor write to active entry %0h", i_wqe_id);

endmodule

/* source/retx_ctrl.sv */
// retransmit control, dma request issue, fetch tracking and transmit command
`timescale 1ns/100ps
`include "retx_defs.svh"

module retx_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`RETX_IDX_W-1:0]      i_retx_id,
    input  logic [`RETX_PSN_W-1:0]      i_retx_psn,
    input  logic                        i_retx_valid,
    output logic                        o_retx_ready,
    input  logic [`RETX_IDX_W-1:0]      i_dma_status_tag,
    input  logic                        i_dma_status_valid,
    input  logic [`RETX_IDX_W-1:0]      i_cpl_id,
    input  logic                        i_cpl_valid,
    dma_req_if.master                   dma_req,
    tbl_rd_if.master                    tx_rd,
    tbl_rd_if.master                    retx_rd,
    output logic                        o_psn_push,
    output logic [`RETX_PSN_W-1:0]      o_psn,
    output logic                        o_psn_pop,
    input  logic [`RETX_PSN_W-1:0]      i_psn_head,
    input  logic                        i_psn_afull,
    output logic [`RETX_RAM_ADDR_W-1:0] o_tx_addr,
    output logic [`RETX_IDX_W-1:0]      o_tx_tag,
    output tx_hdr_pkg::tx_hdr_u         o_tx_hdr,
    output logic                        o_tx_valid,
    input  logic                        i_tx_ready
);

    localparam logic [`RETX_RAM_ADDR_W-1:0] PKT_INC = `RETX_PKT_LEN;

    logic                          accept;
    logic [`RETX_DMA_ADDR_W-1:0]   psn_offset;
    logic [`RETX_RAM_ADDR_W-1:0]   buf_wr_ptr;
    logic [`RETX_RAM_ADDR_W-1:0]   buf_rd_ptr;
    logic [`RETX_IDX_W-1:0]        start_ptr;
    logic [`RETX_TABLE_DEPTH-1:0]  fetched;
    logic                          tx_start;
    logic                          tx_done;
    tx_hdr_pkg::tx_hdr_u           hdr_next;

    // request side
    assign o_retx_ready = dma_req.ready && !i_psn_afull;
    assign accept       = i_retx_valid && o_retx_ready;

    assign retx_rd.rd_idx = i_retx_id;
    assign psn_offset     = {{(`RETX_DMA_ADDR_W-`RETX_PSN_W){1'b0}}, i_retx_psn}
                            << `RETX_PKT_SHIFT;

    assign dma_req.dma_addr = retx_rd.entry.f.laddr + psn_offset;
    assign dma_req.ram_addr = buf_wr_ptr;
    assign dma_req.tag      = i_retx_id;
    assign dma_req.valid    = accept;

    assign o_psn_push = accept;
    assign o_psn      = i_retx_psn;

    // transmit side looks at the last fetched index
    assign tx_rd.rd_idx = start_ptr;
    assign tx_start     = tx_rd.active && fetched[start_ptr] && !o_tx_valid;
    assign tx_done      = o_tx_valid && i_tx_ready;
    assign o_psn_pop    = tx_done;

    always_comb begin
        hdr_next.f.raddr    = tx_rd.entry.f.raddr;
        hdr_next.f.task_id  = tx_rd.entry.f.task_id;
        hdr_next.f.prio     = tx_rd.entry.f.prio;
        hdr_next.f.fence    = tx_rd.entry.f.fence;
        hdr_next.f.psn      = i_psn_head;
        hdr_next.f.msn      = tx_rd.msn;
        hdr_next.f.dst_qpn  = tx_rd.entry.f.dst_qpn;
        hdr_next.f.src_qpn  = tx_rd.src_qpn;
        hdr_next.f.src_port = tx_rd.entry.f.src_port;
        hdr_next.f.rip      = tx_rd.entry.f.rip;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_wr_ptr <= '0;
            buf_rd_ptr <= '0;
            start_ptr  <= '0;
            fetched    <= '0;
            o_tx_valid <= 1'b0;
        end else begin
            if (accept) begin
                buf_wr_ptr <= buf_wr_ptr + PKT_INC;
            end
            if (tx_done) begin
                o_tx_valid        <= 1'b0;
                fetched[o_tx_tag] <= 1'b0;
            end
            if (i_cpl_valid) begin
                fetched[i_cpl_id] <= 1'b0;
            end
            // new status wins over a same-cycle clear
            if (i_dma_status_valid) begin
                fetched[i_dma_status_tag] <= 1'b1;
                start_ptr                 <= i_dma_status_tag;
            end
            if (tx_start) begin
                o_tx_valid <= 1'b1;
                buf_rd_ptr <= buf_rd_ptr + PKT_INC;
            end
        end
    end

    // command fields load only when nothing is pending
    always_ff @(posedge clk) begin
        if (tx_start) begin
            o_tx_addr <= buf_rd_ptr;
            o_tx_tag  <= start_ptr;
            o_tx_hdr  <= hdr_next;
        end
    end

    // fetched data must belong to a live descriptor
    assert property (@(posedge clk) disable iff (rst)
        i_dma_status_valid && !(i_cpl_valid && i_cpl_id == i_dma_status_tag)
        |=> tx_rd.active)
        else $error("retx_ctrl: status for inactive entry %0h", start_ptr);

endmodule

/* source/retx_engine_top.sv */
// retransmit engine top, descriptor table, request path and transmit issue
`timescale 1ns/100ps
`include "retx_defs.svh"

module retx_engine_top (
    input  logic                        clk,
    input  logic                        rst,
    input  wqe_pkg::wqe_word_u          i_wqe_data,
    input  logic [`RETX_QPN_W-1:0]      i_wqe_qpn,
    input  logic [`RETX_IDX_W-1:0]      i_wqe_id,
    input  logic                        i_wqe_valid,
    input  logic [`RETX_IDX_W-1:0]      i_retx_id,
    input  logic [`RETX_PSN_W-1:0]      i_retx_psn,
    input  logic                        i_retx_valid,
    output logic                        o_retx_ready,
    output logic [`RETX_DMA_ADDR_W-1:0] o_dma_addr,
    output logic [`RETX_RAM_ADDR_W-1:0] o_dma_ram_addr,
    output logic [`RETX_IDX_W-1:0]      o_dma_tag,
    output logic                        o_dma_valid,
    input  logic                        i_dma_ready,
    input  logic [`RETX_IDX_W-1:0]      i_dma_status_tag,
    input  logic                        i_dma_status_valid,
    output logic [`RETX_RAM_ADDR_W-1:0] o_tx_addr,
    output logic [`RETX_IDX_W-1:0]      o_tx_tag,
    output tx_hdr_pkg::tx_hdr_u         o_tx_hdr,
    output logic                        o_tx_valid,
    input  logic                        i_tx_ready,
    input  logic [`RETX_IDX_W-1:0]      i_cpl_id,
    input  logic                        i_cpl_valid
);

    logic                   psn_push;
    logic [`RETX_PSN_W-1:0] psn;
    logic                   psn_pop;
    logic [`RETX_PSN_W-1:0] psn_head;
    logic                   psn_afull;

    dma_req_if dma_req ();
    tbl_rd_if  tx_rd ();
    tbl_rd_if  retx_rd ();

    retx_ctrl u_ctrl (
        .clk, .rst,
        .i_retx_id, .i_retx_psn, .i_retx_valid, .o_retx_ready,
        .i_dma_status_tag, .i_dma_status_valid,
        .i_cpl_id, .i_cpl_valid,
        .dma_req    (dma_req),
        .tx_rd      (tx_rd),
        .retx_rd    (retx_rd),
        .o_psn_push (psn_push),
        .o_psn      (psn),
        .o_psn_pop  (psn_pop),
        .i_psn_head (psn_head),
        .i_psn_afull(psn_afull),
        .o_tx_addr, .o_tx_tag, .o_tx_hdr, .o_tx_valid, .i_tx_ready
    );

    wqe_table u_table (
        .clk, .rst,
        .i_wqe_data, .i_wqe_qpn, .i_wqe_id, .i_wqe_valid,
        .i_cpl_id, .i_cpl_valid,
        .tx_rd      (tx_rd),
        .retx_rd    (retx_rd)
    );

    psn_fifo u_fifo (
        .clk, .rst,
        .i_push     (psn_push),
        .i_push_psn (psn),
        .i_pop      (psn_pop),
        .o_head_psn (psn_head),
        .o_empty    (),
        .o_afull    (psn_afull)
    );

    dma_req_skid u_skid (
        .clk, .rst,
        .req_in     (dma_req),
        .o_dma_addr, .o_dma_ram_addr, .o_dma_tag, .o_dma_valid, .i_dma_ready
    );

endmodule

/* dv/tb_retx_engine.sv */
// retransmit engine testbench, random descriptors, stalled dma and transmit, checks by assertion
`timescale 1ns/100ps
`include "retx_defs.svh"

module tb_retx_engine;

    localparam logic [31:0] SEED       = 32'hdf0a42d6;
    localparam int          N_DESC     = 8;
    localparam int          N_REQ      = 12;
    // about 200 cycles of stimulus, twenty times over
    localparam int          MAX_CYCLES = 4000;

    typedef struct packed {
        logic [`RETX_DMA_ADDR_W-1:0] addr;
        logic [`RETX_RAM_ADDR_W-1:0] ram;
        logic [`RETX_IDX_W-1:0]      tag;
    } dma_exp_t;

    typedef struct packed {
        logic [`RETX_RAM_ADDR_W-1:0] addr;
        logic [`RETX_IDX_W-1:0]      tag;
        tx_hdr_pkg::tx_hdr_u         hdr;
    } tx_exp_t;

    logic                        clk = 1'b0;
    logic                        rst;
    wqe_pkg::wqe_word_u          i_wqe_data;
    logic [`RETX_QPN_W-1:0]      i_wqe_qpn;
    logic [`RETX_IDX_W-1:0]      i_wqe_id;
    logic                        i_wqe_valid;
    logic [`RETX_IDX_W-1:0]      i_retx_id;
    logic [`RETX_PSN_W-1:0]      i_retx_psn;
    logic                        i_retx_valid;
    logic                        o_retx_ready;
    logic [`RETX_DMA_ADDR_W-1:0] o_dma_addr;
    logic [`RETX_RAM_ADDR_W-1:0] o_dma_ram_addr;
    logic [`RETX_IDX_W-1:0]      o_dma_tag;
    logic                        o_dma_valid;
    logic                        i_dma_ready;
    logic [`RETX_IDX_W-1:0]      i_dma_status_tag;
    logic                        i_dma_status_valid;
    logic [`RETX_RAM_ADDR_W-1:0] o_tx_addr;
    logic [`RETX_IDX_W-1:0]      o_tx_tag;
    tx_hdr_pkg::tx_hdr_u         o_tx_hdr;
    logic                        o_tx_valid;
    logic                        i_tx_ready;
    logic [`RETX_IDX_W-1:0]      i_cpl_id;
    logic                        i_cpl_valid;

    // reference model of the descriptor table, raw words in the field layout of the bus
    logic [255:0]            m_entry [`RETX_TABLE_DEPTH];
    logic [`RETX_QPN_W-1:0]  m_qpn   [`RETX_TABLE_DEPTH];
    logic [`RETX_PSN_W-1:0]  m_msn   [`RETX_TABLE_DEPTH];
    logic [`RETX_PSN_W-1:0]  m_cnt   [`RETX_MSN_QPS];
    dma_exp_t                exp_dma_q[$];
    tx_exp_t                 exp_tx_q[$];

    int          dma_rd = 0;
    int          tx_rd = 0;
    int          status_cnt = 0;
    int          cycle_cnt = 0;
    int          err_dma = 0;
    int          err_tx = 0;
    int          err_misc = 0;
    logic [31:0] rng = SEED;
    logic [1:0]  rst_hist = 2'b11;
    logic        dma_stall = 1'b0;
    logic        tx_stall = 1'b0;
    logic [84:0] dma_prev;
    logic [252:0] tx_prev;

    retx_engine_top dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic write_desc(input logic [`RETX_IDX_W-1:0] idx);
        logic [255:0]           w;
        logic [31:0]            r;
        logic [`RETX_QPN_W-1:0] qpn;
        for (int k = 0; k < 8; k++) begin
            w[k*32 +: 32] = rand32();
        end
        r = rand32();
        // few distinct low bits so several descriptors share an msn counter
        qpn = {r[23:4], 2'b00, r[1:0]};
        m_entry[idx] = w;
        m_qpn[idx] = qpn;
        m_msn[idx] = m_cnt[qpn[3:0]];
        m_cnt[qpn[3:0]] = m_cnt[qpn[3:0]] + 24'd1;
        i_wqe_data.raw = w;
        i_wqe_qpn = qpn;
        i_wqe_id = idx;
        i_wqe_valid = 1'b1;
        @(negedge clk);
        i_wqe_valid = 1'b0;
    endtask

    task automatic send_retx(input logic [`RETX_IDX_W-1:0] idx, input logic [23:0] psn);
        dma_exp_t d;
        tx_exp_t  t;
        logic     took;
        d.addr = m_entry[idx][127:64] + 64'(psn) * 64'(`RETX_PKT_LEN);
        d.ram = 16'(exp_dma_q.size() * `RETX_PKT_LEN);
        d.tag = idx;
        t.addr = 16'(exp_tx_q.size() * `RETX_PKT_LEN);
        t.tag = idx;
        // raddr, task id, prio, fence, psn, msn, dst qpn, src qpn, src port, rip
        t.hdr.raw = {m_entry[idx][191:128], m_entry[idx][255:236], m_entry[idx][234:232],
                     m_entry[idx][235], psn, m_msn[idx], m_entry[idx][215:192],
                     m_qpn[idx], m_entry[idx][231:216], m_entry[idx][63:32]};
        exp_dma_q.push_back(d);
        exp_tx_q.push_back(t);
        i_retx_id = idx;
        i_retx_psn = psn;
        i_retx_valid = 1'b1;
        do begin
            took = o_retx_ready;
            @(negedge clk);
        end while (!took);
        i_retx_valid = 1'b0;
    endtask

    task automatic wait_dma_drain();
        while (dma_rd < exp_dma_q.size()) begin
            @(negedge clk);
        end
    endtask

    task automatic send_status(input logic [`RETX_IDX_W-1:0] tag);
        logic [31:0] r;
        i_dma_status_tag = tag;
        i_dma_status_valid = 1'b1;
        status_cnt++;
        @(negedge clk);
        i_dma_status_valid = 1'b0;
        while (tx_rd < status_cnt) begin
            r = rand32();
            i_tx_ready = (r[1:0] == 2'b00);
            @(negedge clk);
        end
        i_tx_ready = 1'b0;
    endtask

    task automatic complete_entry(input logic [`RETX_IDX_W-1:0] idx);
        i_cpl_id = idx;
        i_cpl_valid = 1'b1;
        @(negedge clk);
        i_cpl_valid = 1'b0;
    endtask

    task automatic report_counts();
        $display("errors: dma %0d, transmit %0d, other %0d", err_dma, err_tx, err_misc);
    endtask

    initial begin : clock_gen
        forever #2 clk = ~clk;
    end

    initial begin : dma_ready_drive
        int          stall_left;
        logic [31:0] s;
        stall_left = 0;
        s = xorshift32(SEED ^ 32'h5a5a5a5a);
        i_dma_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (stall_left > 0) begin
                stall_left--;
                i_dma_ready = 1'b0;
            end else begin
                s = xorshift32(s);
                // one cycle in four starts a stall of up to seven more
                stall_left = (s[1:0] == 2'b00) ? int'(s[4:2]) : 0;
                i_dma_ready = (s[1:0] != 2'b00);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        rst_hist <= {rst_hist[0], rst};
        if (o_dma_valid && i_dma_ready) begin
            dma_rd <= dma_rd + 1;
        end
        if (o_tx_valid && i_tx_ready) begin
            tx_rd <= tx_rd + 1;
        end
        dma_stall <= o_dma_valid && !i_dma_ready;
        dma_prev <= {o_dma_addr, o_dma_ram_addr, o_dma_tag};
        tx_stall <= o_tx_valid && !i_tx_ready;
        tx_prev <= {o_tx_addr, o_tx_tag, o_tx_hdr};
    end

    // outputs are registered, so they are settled at the falling edge
    a_rst_quiet: assert property (@(negedge clk)
        (cycle_cnt > 0 && (rst || rst_hist != 2'b00)) |-> !o_dma_valid && !o_tx_valid)
        else begin
            err_misc++;
            $display("error: valid high around reset, o_dma_valid %h o_tx_valid %h",
                     o_dma_valid, o_tx_valid);
        end

    // request ready is low in reset and comes up one cycle after it
    a_ready_rst: assert property (@(negedge clk)
        (cycle_cnt > 0 && rst_hist[0]) |-> !o_retx_ready)
        else begin
            err_misc++;
            $display("error: o_retx_ready got %h expected 0 in reset", o_retx_ready);
        end
    a_ready_rise: assert property (@(negedge clk)
        rst_hist == 2'b10 |-> o_retx_ready)
        else begin
            err_misc++;
            $display("error: o_retx_ready got %h expected 1 after reset", o_retx_ready);
        end

    a_dma_owed: assert property (@(negedge clk) disable iff (rst)
        o_dma_valid |-> dma_rd < exp_dma_q.size())
        else begin
            err_dma++;
            $display("dma request appeared with no retransmit request outstanding");
        end
    a_dma_addr: assert property (@(negedge clk) disable iff (rst)
        o_dma_valid |-> o_dma_addr == exp_dma_q[dma_rd].addr)
        else begin
            err_dma++;
            $display("error: o_dma_addr got %h expected %h", o_dma_addr, exp_dma_q[dma_rd].addr);
        end
    a_dma_ram: assert property (@(negedge clk) disable iff (rst)
        o_dma_valid |-> o_dma_ram_addr == exp_dma_q[dma_rd].ram)
        else begin
            err_dma++;
            $display("error: o_dma_ram_addr got %h expected %h",
                     o_dma_ram_addr, exp_dma_q[dma_rd].ram);
        end
    a_dma_tag: assert property (@(negedge clk) disable iff (rst)
        o_dma_valid |-> o_dma_tag == exp_dma_q[dma_rd].tag)
        else begin
            err_dma++;
            $display("error: o_dma_tag got %h expected %h", o_dma_tag, exp_dma_q[dma_rd].tag);
        end
    a_dma_hold: assert property (@(negedge clk) disable iff (rst)
        dma_stall |-> o_dma_valid && {o_dma_addr, o_dma_ram_addr, o_dma_tag} == dma_prev)
        else begin
            err_dma++;
            $display("error: stalled o_dma_addr, o_dma_ram_addr, o_dma_tag got %h expected %h",
                     {o_dma_addr, o_dma_ram_addr, o_dma_tag}, dma_prev);
        end

    a_tx_owed: assert property (@(negedge clk) disable iff (rst)
        o_tx_valid |-> tx_rd < status_cnt)
        else begin
            err_tx++;
            $display("transmit command appeared without a pending dma status");
        end
    a_tx_addr: assert property (@(negedge clk) disable iff (rst)
        o_tx_valid |-> o_tx_addr == exp_tx_q[tx_rd].addr)
        else begin
            err_tx++;
            $display("error: o_tx_addr got %h expected %h", o_tx_addr, exp_tx_q[tx_rd].addr);
        end
    a_tx_tag: assert property (@(negedge clk) disable iff (rst)
        o_tx_valid |-> o_tx_tag == exp_tx_q[tx_rd].tag)
        else begin
            err_tx++;
            $display("error: o_tx_tag got %h expected %h", o_tx_tag, exp_tx_q[tx_rd].tag);
        end
    a_tx_hdr: assert property (@(negedge clk) disable iff (rst)
        o_tx_valid |-> o_tx_hdr.raw == exp_tx_q[tx_rd].hdr.raw)
        else begin
            err_tx++;
            $display("error: o_tx_hdr got %h expected %h", o_tx_hdr.raw, exp_tx_q[tx_rd].hdr.raw);
        end
    a_tx_hold: assert property (@(negedge clk) disable iff (rst)
        tx_stall |-> o_tx_valid && {o_tx_addr, o_tx_tag, o_tx_hdr} == tx_prev)
        else begin
            err_tx++;
            $display("error: stalled o_tx_addr, o_tx_tag, o_tx_hdr got %h expected %h",
                     {o_tx_addr, o_tx_tag, o_tx_hdr}, tx_prev);
        end

    initial begin : stimulus
        logic [31:0]            r;
        logic [`RETX_IDX_W-1:0] idx;
        rst = 1'b1;
        i_wqe_data.raw = '0;
        i_wqe_qpn = '0;
        i_wqe_id = '0;
        i_wqe_valid = 1'b0;
        i_retx_id = '0;
        i_retx_psn = '0;
        i_retx_valid = 1'b0;
        i_dma_status_tag = '0;
        i_dma_status_valid = 1'b0;
        i_tx_ready = 1'b0;
        i_cpl_id = '0;
        i_cpl_valid = 1'b0;
        for (int q = 0; q < `RETX_MSN_QPS; q++) begin
            m_cnt[q] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int i = 0; i < N_DESC; i++) begin
            write_desc(5'(i));
        end
        for (int i = 0; i < N_REQ; i++) begin
            r = rand32();
            send_retx(5'(r % N_DESC), r[31:8]);
        end
        wait_dma_drain();
        // status comes back in request order
        for (int i = 0; i < N_REQ; i++) begin
            send_status(exp_dma_q[i].tag);
        end

        // free an index, reload it, and retransmit from the new descriptor
        for (int i = 0; i < 2; i++) begin
            r = rand32();
            idx = 5'(r % N_DESC);
            complete_entry(idx);
            write_desc(idx);
            send_retx(idx, r[31:8]);
            wait_dma_drain();
            send_status(idx);
        end
        repeat (5) @(negedge clk);

        a_all_dma: assert (dma_rd == exp_dma_q.size())
            else begin
                err_misc++;
                $display("only %0d of %0d dma requests were issued", dma_rd, exp_dma_q.size());
            end
        report_counts();
        if (err_dma + err_tx + err_misc == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        report_counts();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+source
source/wqe_pkg.sv
source/tx_hdr_pkg.sv
source/retx_if.sv
source/psn_fifo.sv
source/dma_req_skid.sv
source/wqe_table.sv
source/retx_ctrl.sv
source/retx_engine_top.sv
dv/tb_retx_engine.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the retransmit engine testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_retx_engine -Mdir obj_dir -o sim_retx
./obj_dir/sim_retx | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
